// File: common/sparcCtrlPkg.sv
/*
 * Sequencer control types.
 * Control word between the FSM and the datapath blocks,
 * trap encodings and FSM state names.
 */
package sparcCtrlPkg;
`include "sparc_params.svh"

        typedef logic [`XLEN-1:0]     addr_t;
        typedef logic [`CWP_W-1:0]    cwp_t;
        typedef logic [`NWINDOWS-1:0] wim_t;

        typedef enum logic [7:0] {ttIllegal = 8'h02, ttWinOverflow = 8'h05,
                                  ttWinUnderflow = 8'h06, ttSoftware = 8'h80} trapType_e;

        // one bit per trap source
        typedef struct packed {logic overflow; logic underflow; logic software;
                               logic illegal;} trapSet_t;

        typedef enum logic [2:0] {pcHold, pcSequential, pcBranchTaken, pcAnnulSkip,
                                  pcTrapVector} pcOp_e;

        typedef struct packed {
                pcOp_e    pcOp;
                logic     windowSave;
                logic     windowRestore;
                logic     wimWrite;
                trapSet_t trapPost;
                logic     trapEnter;
        } ctrlWord_t;

        typedef enum logic [3:0] {
                sReset,
                sFetch,
                sDecode,
                sBranch,
                sBranchCheck,
                sWindow,
                sTicc,
                sWrWim,
                sIllegal,
                sSequential,
                sEndCheck,
                sTrapEnter
        } seqState_e;

endpackage

// File: common/sparcIsaPkg.sv
/*
 * SPARC ISA types.
 * Instruction formats, opcode fields and integer condition codes.
 */
package sparcIsaPkg;
`include "sparc_params.svh"

        typedef logic [`XLEN-1:0] instrWord_t;

        typedef enum logic [1:0] {opFmt2 = 2'b00, opCall = 2'b01, opArith = 2'b10,
                                  opMem = 2'b11} opClass_e;

        typedef enum logic [2:0] {op2Unimp = 3'b000, op2Bicc = 3'b010,
                                  op2Sethi = 3'b100} op2_e;

        typedef enum logic [5:0] {op3WrWim = 6'b110010, op3Ticc = 6'b111010,
                                  op3Save = 6'b111100, op3Restore = 6'b111101} op3_e;

        typedef enum logic [3:0] {condNever, condE, condLe, condL, condLeu, condCs,
                                  condNeg, condVs, condAlways, condNe, condG, condGe,
                                  condGu, condCc, condPos, condVc} cond_e;

        typedef struct packed {logic n; logic z; logic v; logic c;} iccFlags_t;

        // branch format, op = 0
        typedef struct packed {opClass_e op; logic annul; cond_e cond; op2_e op2;
                               logic [21:0] disp22;} fmt2_t;

        // arithmetic format, op = 2
        typedef struct packed {opClass_e op; logic [4:0] rd; op3_e op3; logic [4:0] rs1;
                               logic i; logic [12:0] simm13;} fmt3_t;

        typedef union packed {fmt2_t f2; fmt3_t f3;} sparcInstr_t;

endpackage

// File: common/sparc_params.svh
/*
 * SPARC sequencer parameters.
 * Widths, window count, branch limit, trap base and reset mask.
 */
`ifndef SPARC_PARAMS_SVH
`define SPARC_PARAMS_SVH

`define XLEN       32
`define NWINDOWS   8
`define CWP_W      3
`define ADDR_LIMIT 508
`define TRAP_BASE  32'h100
`define WIM_RESET  8'h00

`endif

// File: control/branchCond.sv
/*
 * Integer condition evaluation.
 * Maps the 4-bit condition field onto the N, Z, V and C flags.
 */
`timescale 1ns/1ns

module branchCond
        import sparcIsaPkg::*;
(
        input  cond_e     cond,
        input  iccFlags_t icc,
        output logic      taken
);

        always_comb
        begin
                case (cond)
                        condAlways: taken = 1'b1;
                        condNever:  taken = 1'b0;
                        condE:      taken = icc.z;
                        condNe:     taken = !icc.z;
                        condLe:     taken = icc.z | (icc.n ^ icc.v);
                        condG:      taken = !(icc.z | (icc.n ^ icc.v));
                        condL:      taken = icc.n ^ icc.v;
                        condGe:     taken = !(icc.n ^ icc.v);
                        condLeu:    taken = icc.c | icc.z;    // unsigned compares
                        condGu:     taken = !(icc.c | icc.z);
                        condCs:     taken = icc.c;
                        condCc:     taken = !icc.c;
                        condNeg:    taken = icc.n;
                        condPos:    taken = !icc.n;
                        condVs:     taken = icc.v;
                        condVc:     taken = !icc.v;
                        default:    taken = 1'b0;
                endcase
        end

endmodule

// File: control/ctrlFsm.sv
/*
 * Sequencer control FSM.
 * Fetches over the request/acknowledge strobes, decodes the word
 * and issues one-cycle control pulses, then enters pending traps.
 */
`timescale 1ns/1ns

module ctrlFsm
        import sparcIsaPkg::*;
        import sparcCtrlPkg::*;
(
        input  logic        Clk,
        input  logic        rstN,
        input  logic        memAck,
        input  instrWord_t  memData,
        input  iccFlags_t   icc,
        output logic        memReq,
        output ctrlWord_t   ctrl,
        output sparcInstr_t instr,
        output cwp_t        cwp,
        output logic        trapTaken,
        input  logic        rangeBad,
        input  logic        pending
);

        seqState_e   state;
        seqState_e   nextState;
        sparcInstr_t ir;
        iccFlags_t   iccReg;        // flags seen during the fetch
        logic        condTrue;
        logic        overflow;
        logic        underflow;
        logic        isSave;
        logic        windowTrap;

        always_ff @(posedge Clk)
        begin
                if (!rstN)
                        state <= sReset;
                else
                        state <= nextState;
        end

        // instruction and flags latched with the acknowledge
        always_ff @(posedge Clk)
        begin
                if (state == sFetch && memAck)
                begin
                        ir     <= sparcInstr_t'(memData);
                        iccReg <= icc;
                end
        end

        branchCond branchCond_i (
                .cond (ir.f2.cond),
                .icc  (iccReg),
                .taken(condTrue)
        );

        windowMgr windowMgr_i (
                .Clk      (Clk),
                .rstN     (rstN),
                .ctrl     (ctrl),
                .instr    (ir),
                .cwp      (cwp),
                .overflow (overflow),
                .underflow(underflow)
        );

        assign isSave     = (ir.f3.op3 == op3Save);
        assign windowTrap = isSave ? overflow : underflow;

        always_comb
        begin
                nextState = state;
                ctrl      = '0;
                ctrl.pcOp = pcHold;
                case (state)
                        sReset: nextState = sFetch;
                        sFetch: if (memAck) nextState = sDecode;
                        sDecode:
                        begin
                                case (ir.f2.op)
                                        opFmt2: nextState = (ir.f2.op2 == op2Bicc) ? sBranch : sIllegal;
                                        opArith:
                                        begin
                                                case (ir.f3.op3)
                                                        op3Save, op3Restore: nextState = sWindow;
                                                        op3Ticc:             nextState = sTicc;
                                                        op3WrWim:            nextState = sWrWim;
                                                        default:             nextState = sSequential; // no datapath
                                                endcase
                                        end
                                        default: nextState = sIllegal;   // call and memory ops
                                endcase
                        end
                        sBranch:
                        begin
                                if (condTrue)
                                begin
                                        ctrl.pcOp = pcBranchTaken;
                                        nextState = sBranchCheck;
                                end
                                else
                                begin
                                        ctrl.pcOp = ir.f2.annul ? pcAnnulSkip : pcSequential;
                                        nextState = sEndCheck;
                                end
                        end
                        sBranchCheck:
                        begin
                                ctrl.trapPost.illegal = rangeBad;  // target out of range
                                nextState = sEndCheck;
                        end
                        sWindow:
                        begin
                                if (windowTrap)
                                begin
                                        ctrl.trapPost.overflow  = isSave;
                                        ctrl.trapPost.underflow = !isSave;
                                        nextState = sEndCheck;
                                end
                                else
                                begin
                                        ctrl.windowSave    = isSave;
                                        ctrl.windowRestore = !isSave;
                                        nextState = sSequential;
                                end
                        end
                        sTicc:
                        begin
                                ctrl.trapPost.software = condTrue;
                                nextState = sSequential;
                        end
                        sWrWim:
                        begin
                                ctrl.wimWrite = 1'b1;
                                nextState = sSequential;
                        end
                        sIllegal:
                        begin
                                ctrl.trapPost.illegal = 1'b1;
                                nextState = sEndCheck;
                        end
                        sSequential:
                        begin
                                ctrl.pcOp = pcSequential;
                                nextState = sEndCheck;
                        end
                        sEndCheck: nextState = pending ? sTrapEnter : sFetch;
                        sTrapEnter:
                        begin
                                ctrl.trapEnter = 1'b1;
                                ctrl.pcOp      = pcTrapVector;
                                nextState = sFetch;
                        end
                        default: nextState = sReset;
                endcase
        end

        assign memReq    = (state == sFetch);
        assign trapTaken = (state == sTrapEnter);
        assign instr     = ir;

endmodule

// File: control/windowMgr.sv
/*
 * Register window manager.
 * Holds the window pointer and invalid mask and flags
 * overflow and underflow for save and restore.
 */
`timescale 1ns/1ns
`include "sparc_params.svh"

module windowMgr
        import sparcIsaPkg::*;
        import sparcCtrlPkg::*;
(
        input  logic        Clk,
        input  logic        rstN,
        input  ctrlWord_t   ctrl,
        input  sparcInstr_t instr,
        output cwp_t        cwp,
        output logic        overflow,
        output logic        underflow
);

        wim_t wim;
        cwp_t cwpDec;
        cwp_t cwpInc;

        assign cwpDec = cwp_t'((cwp + `NWINDOWS - 1) % `NWINDOWS);
        assign cwpInc = cwp_t'((cwp + 1) % `NWINDOWS);

        assign overflow  = wim[cwpDec];    // window a save would enter
        assign underflow = wim[cwpInc];

        always_ff @(posedge Clk)
        begin
                if (!rstN)
                begin
                        cwp <= '0;
                        wim <= `WIM_RESET;
                end
                else
                begin
                        if (ctrl.trapEnter)
                                cwp <= '0;
                        else if (ctrl.windowSave)
                                cwp <= cwpDec;
                        else if (ctrl.windowRestore)
                                cwp <= cwpInc;
                        if (ctrl.wimWrite)
                                wim <= instr.f3.simm13[7:0];
                end
        end

endmodule

// File: dv/sparcSequencerTb.sv
/*
 * Testbench for the SPARC instruction sequencer.
 * Serves fetches from a random program memory and checks the DUT
 * against a model of PC, nPC, cwp, wim and trap entry.
 */
`timescale 1ns/1ns
`include "sparc_params.svh"

module sparcSequencerTb
        import sparcIsaPkg::*;
        import sparcCtrlPkg::*;
();

        localparam int numInstr      = 400;
        localparam int timeoutCycles = numInstr * 12;
        localparam int maxGap        = 8;             // decode to next fetch, trap included

        logic       Clk;
        logic       rstN;
        logic       memAck;
        instrWord_t memData;
        iccFlags_t  icc;
        logic       memReq;
        addr_t      memAddr;
        cwp_t       cwp;
        logic       trapTaken;
        trapType_e  trapType;

        instrWord_t progMem [addr_t];                 // filled on first fetch of an address
        addr_t      modelPc;
        addr_t      modelNpc;
        cwp_t       modelCwp;
        wim_t       modelWim;
        int         cycleCount;

        sparcSequencer sparcSequencer_i (
                .Clk      (Clk),
                .rstN     (rstN),
                .memAck   (memAck),
                .memData  (memData),
                .icc      (icc),
                .memReq   (memReq),
                .memAddr  (memAddr),
                .cwp      (cwp),
                .trapTaken(trapTaken),
                .trapType (trapType)
        );

        always #2 Clk = ~Clk;

        task automatic failAndStop();
                $display("Test failures found");
                $fatal(1, "stopping after the first error");
        endtask

        always @(posedge Clk)
        begin
                cycleCount <= cycleCount + 1;
                if (cycleCount > timeoutCycles)
                begin
                        $display("run exceeded %0d cycles without finishing", timeoutCycles);
                        failAndStop();
                end
        end

        task automatic checkAddr(input string name, input addr_t got, input addr_t exp);
                if (got !== exp)
                begin
                        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
                        failAndStop();
                end
        endtask

        task automatic checkCwp(input string name, input cwp_t got, input cwp_t exp);
                if (got !== exp)
                begin
                        $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
                        failAndStop();
                end
        endtask

        task automatic checkTrap(input string name, input trapType_e got, input trapType_e exp);
                if (got !== exp)
                begin
                        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
                        failAndStop();
                end
        endtask

        // lower eight codes are the base tests, upper eight their negation
        function automatic logic condHolds(input logic [3:0] cond, input iccFlags_t f);
                logic base;
                case (cond[2:0])
                        3'd0:    base = 1'b0;
                        3'd1:    base = f.z;
                        3'd2:    base = f.z | (f.n ^ f.v);
                        3'd3:    base = f.n ^ f.v;
                        3'd4:    base = f.c | f.z;
                        3'd5:    base = f.c;
                        3'd6:    base = f.n;
                        default: base = f.v;
                endcase
                return cond[3] ? !base : base;
        endfunction

        function automatic instrWord_t randomInstr();
                int          pick;
                logic [21:0] disp;
                logic [3:0]  cond;
                logic [5:0]  op3;
                logic [2:0]  op2;
                logic [7:0]  mask;
                pick = int'($urandom_range(99, 0));
                disp = 22'($urandom_range(40, 0)) - 22'd12;   // -12 to +28 words
                cond = 4'($urandom_range(15, 0));
                op3  = 6'($urandom_range(31, 0));             // below every kept op3
                op2  = 3'($urandom_range(7, 0));
                mask = 8'($urandom_range(255, 0)) & 8'($urandom_range(255, 0));
                if (op2 == 3'b010)
                        op2 = 3'b100;
                if (pick < 34)
                        return {2'b00, 1'($urandom_range(1, 0)), cond, 3'b010, disp};
                else if (pick < 46)
                        return {2'b10, 5'($urandom), 6'b111100, 19'($urandom)};
                else if (pick < 58)
                        return {2'b10, 5'($urandom), 6'b111101, 19'($urandom)};
                else if (pick < 66)
                        return {2'b10, 1'b0, cond, 6'b111010, 19'($urandom)};
                else if (pick < 74)
                        return {2'b10, 5'($urandom), 6'b110010, 5'($urandom), 1'b1, 5'b00000, mask};
                else if (pick < 90)
                        return {2'b10, 5'($urandom), op3, 19'($urandom)};
                else if (pick < 94)
                        return {2'b01, 30'($urandom)};        // call
                else if (pick < 97)
                        return {2'b11, 30'($urandom)};        // load/store class
                else
                        return {2'b00, 5'($urandom), op2, disp};
        endfunction

        task automatic advancePc();
                modelPc  = modelNpc;
                modelNpc = modelNpc + 4;
        endtask

        task automatic stepModel(input instrWord_t word, input iccFlags_t flags,
                                 output logic trapExp, output logic [7:0] ttExp);
                addr_t target;
                cwp_t  nextCwp;
                logic  isSave;
                trapExp = 1'b0;
                ttExp   = 8'h02;
                target  = modelPc + {{8{word[21]}}, word[21:0], 2'b00};
                isSave  = (word[24:19] == 6'b111100);
                nextCwp = isSave ? modelCwp - cwp_t'(1) : modelCwp + cwp_t'(1);  // wraps mod 8
                case (word[31:30])
                        2'b00:
                        begin
                                if (word[24:22] != 3'b010)
                                        trapExp = 1'b1;
                                else if (condHolds(word[28:25], flags))
                                begin
                                        modelPc  = modelNpc;           // delay slot first
                                        modelNpc = target;
                                        trapExp  = (modelNpc > addr_t'(`ADDR_LIMIT));
                                end
                                else if (word[29])
                                begin
                                        modelPc  = modelNpc + 4;       // annulled slot
                                        modelNpc = modelNpc + 8;
                                end
                                else
                                        advancePc();
                        end
                        2'b10:
                        begin
                                case (word[24:19])
                                        6'b111100, 6'b111101:
                                        begin
                                                trapExp = modelWim[nextCwp];
                                                ttExp   = isSave ? 8'h05 : 8'h06;
                                                if (!trapExp)
                                                begin
                                                        modelCwp = nextCwp;
                                                        advancePc();
                                                end
                                        end
                                        6'b111010:
                                        begin
                                                advancePc();
                                                trapExp = condHolds(word[28:25], flags);
                                                ttExp   = 8'h80;
                                        end
                                        6'b110010:
                                        begin
                                                modelWim = word[7:0];
                                                advancePc();
                                        end
                                        default: advancePc();         // no-op arithmetic
                                endcase
                        end
                        default: trapExp = 1'b1;                      // call and op=3
                endcase
                if (trapExp)
                begin
                        modelPc  = addr_t'(`TRAP_BASE) + addr_t'({ttExp, 4'h0});
                        modelNpc = modelPc + 4;
                        modelCwp = '0;
                end
        endtask

        // entered at a falling edge with memReq high
        task automatic serveFetch(output instrWord_t word, output iccFlags_t flags);
                int    delay;
                addr_t reqAddr;
                reqAddr = memAddr;
                checkAddr("memAddr", memAddr, modelPc);
                checkCwp("cwp", cwp, modelCwp);
                if (!progMem.exists(reqAddr))
                        progMem[reqAddr] = randomInstr();
                word  = progMem[reqAddr];
                flags = iccFlags_t'(4'($urandom_range(15, 0)));
                delay = int'($urandom_range(3, 0));
                repeat (delay)
                begin
                        @(posedge Clk);
                        icc     <= iccFlags_t'(4'($urandom_range(15, 0)));
                        memData <= instrWord_t'($urandom);    // ignored without ack
                        @(negedge Clk);
                        if (!memReq)
                        begin
                                $display("memReq dropped before the acknowledge at %0t", $time);
                                failAndStop();
                        end
                        checkAddr("memAddr", memAddr, reqAddr);
                end
                @(posedge Clk);
                memAck  <= 1'b1;
                memData <= word;
                icc     <= flags;
                @(posedge Clk);
                memAck  <= 1'b0;
        endtask

        task automatic awaitFetch(input logic expectTrap, input logic [7:0] ttExp,
                                  input int limit);
                int   waited;
                logic trapSeen;
                waited   = 0;
                trapSeen = 1'b0;
                @(negedge Clk);
                while (!memReq)
                begin
                        if (trapTaken)
                        begin
                                if (!expectTrap)
                                begin
                                        $display("trap taken at %0t with no trap expected", $time);
                                        failAndStop();
                                end
                                checkTrap("trapType", trapType, trapType_e'(ttExp));
                                trapSeen = 1'b1;
                        end
                        waited++;
                        if (waited > limit)
                        begin
                                $display("no fetch request within %0d cycles at %0t", limit, $time);
                                failAndStop();
                        end
                        @(negedge Clk);
                end
                if (expectTrap && !trapSeen)
                begin
                        $display("expected trap %h was not taken before %0t", ttExp, $time);
                        failAndStop();
                end
        endtask

        initial
        begin
                instrWord_t word;
                iccFlags_t  flags;
                logic       trapExp;
                logic [7:0] ttExp;
                void'($urandom(32'h9919_c9e4));
                Clk        = 1'b0;
                rstN       = 1'b0;
                memAck     = 1'b0;
                memData    = '0;
                icc        = '0;
                cycleCount = 0;
                modelPc    = '0;
                modelNpc   = addr_t'(4);
                modelCwp   = '0;
                modelWim   = `WIM_RESET;
                repeat (4) @(posedge Clk);
                rstN <= 1'b1;
                awaitFetch(1'b0, 8'h00, 2);                   // first request within 2 cycles
                for (int n = 0; n < numInstr; n++)
                begin
                        serveFetch(word, flags);
                        stepModel(word, flags, trapExp, ttExp);
                        awaitFetch(trapExp, ttExp, maxGap);
                end
                $display("All tests passed!");
                $finish;
        end

endmodule

// File: dv/sparcSequencer_assertions.sv
/*
 * Sequencer handshake and trap checks.
 * Bound into the sequencer top level.
 */
`timescale 1ns/1ns

module sparcSequencer_assertions
        import sparcCtrlPkg::*;
(
        input logic  Clk,
        input logic  rstN,
        input logic  memReq,
        input logic  memAck,
        input addr_t memAddr,
        input logic  trapTaken
);

        // fetch address held until the acknowledge
        addrStable: assert property (@(posedge Clk) disable iff (!rstN)
                memReq && !memAck |=> $stable(memAddr))
                else $error("memAddr changed while a fetch was pending");

        reqHeld: assert property (@(posedge Clk) disable iff (!rstN)
                memReq && !memAck |=> memReq)
                else $error("memReq fell without an acknowledge");

        trapPulse: assert property (@(posedge Clk) disable iff (!rstN)
                trapTaken |=> !trapTaken)
                else $error("trapTaken held for more than one cycle");

        reqTrapExclusive: assert property (@(posedge Clk) disable iff (!rstN)
                !(memReq && trapTaken))
                else $error("memReq and trapTaken high together");

endmodule

bind sparcSequencer sparcSequencer_assertions sparcSequencer_assertions_i (.*);

// File: hdl/pcUnit.sv
/*
 * Program counter unit.
 * PC and nPC registers with sequential, delayed branch, annul
 * and trap vector updates, plus the branch target range check.
 */
`timescale 1ns/1ns
`include "sparc_params.svh"

module pcUnit
        import sparcIsaPkg::*;
        import sparcCtrlPkg::*;
(
        input  logic        Clk,
        input  logic        rstN,
        input  ctrlWord_t   ctrl,
        input  sparcInstr_t instr,
        input  trapType_e   trapType,
        output addr_t       memAddr,
        output logic        rangeBad
);

        addr_t pc;
        addr_t npc;
        addr_t dispOffset;
        addr_t vecAddr;

        // word displacement, sign extended
        assign dispOffset = {{(`XLEN - 24){instr.f2.disp22[21]}}, instr.f2.disp22, 2'b00};
        assign vecAddr    = addr_t'(`TRAP_BASE) + addr_t'({trapType, 4'b0000});

        always_ff @(posedge Clk)
        begin
                if (!rstN)
                begin
                        pc  <= '0;
                        npc <= addr_t'(4);
                end
                else
                begin
                        case (ctrl.pcOp)
                                pcSequential:
                                begin
                                        pc  <= npc;
                                        npc <= npc + addr_t'(4);
                                end
                                pcBranchTaken:
                                begin
                                        pc  <= npc;                // delay slot first
                                        npc <= pc + dispOffset;
                                end
                                pcAnnulSkip:
                                begin
                                        pc  <= npc + addr_t'(4);
                                        npc <= npc + addr_t'(8);
                                end
                                pcTrapVector:
                                begin
                                        pc  <= vecAddr;
                                        npc <= vecAddr + addr_t'(4);
                                end
                                default: ;                         // hold
                        endcase
                end
        end

        assign rangeBad = (npc > addr_t'(`ADDR_LIMIT));
        assign memAddr  = pc;

endmodule

// File: hdl/sparcSequencer.sv
/*
 * SPARC instruction sequencer top level.
 * Connects the control FSM, the PC unit and the trap queue.
 */
`timescale 1ns/1ns

module sparcSequencer
        import sparcIsaPkg::*;
        import sparcCtrlPkg::*;
(
        input  logic       Clk,
        input  logic       rstN,
        input  logic       memAck,
        input  instrWord_t memData,
        input  iccFlags_t  icc,
        output logic       memReq,
        output addr_t      memAddr,
        output cwp_t       cwp,
        output logic       trapTaken,
        output trapType_e  trapType
);

        ctrlWord_t   ctrl;
        sparcInstr_t instr;     // decoded instruction register
        logic        rangeBad;
        logic        pending;

        ctrlFsm ctrlFsm_i (
                .Clk      (Clk),
                .rstN     (rstN),
                .memAck   (memAck),
                .memData  (memData),
                .icc      (icc),
                .memReq   (memReq),
                .ctrl     (ctrl),
                .instr    (instr),
                .cwp      (cwp),
                .trapTaken(trapTaken),
                .rangeBad (rangeBad),
                .pending  (pending)
        );

        pcUnit pcUnit_i (
                .Clk     (Clk),
                .rstN    (rstN),
                .ctrl    (ctrl),
                .instr   (instr),
                .trapType(trapType),
                .memAddr (memAddr),
                .rangeBad(rangeBad)
        );

        trapQueue trapQueue_i (
                .Clk     (Clk),
                .rstN    (rstN),
                .ctrl    (ctrl),
                .pending (pending),
                .trapType(trapType)
        );

endmodule

// File: hdl/trapQueue.sv
/*
 * Pending trap queue.
 * Collects posted trap causes, picks one by fixed priority
 * and clears on trap entry.
 */
`timescale 1ns/1ns

module trapQueue
        import sparcCtrlPkg::*;
(
        input  logic      Clk,
        input  logic      rstN,
        input  ctrlWord_t ctrl,
        output logic      pending,
        output trapType_e trapType
);

        trapSet_t pend;

        always_ff @(posedge Clk)
        begin
                if (!rstN)
                        pend <= '0;
                else if (ctrl.trapEnter)
                        pend <= '0;
                else
                        pend <= pend | ctrl.trapPost;
        end

        assign pending = |pend;

        // window traps outrank software and illegal
        always_comb
        begin
                if (pend.overflow)
                        trapType = ttWinOverflow;
                else if (pend.underflow)
                        trapType = ttWinUnderflow;
                else if (pend.software)
                        trapType = ttSoftware;
                else
                        trapType = ttIllegal;
        end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the sequencer testbench with Verilator.
cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -f sparcSequencer.f \
        --top-module sparcSequencerTb -o sparcSequencerSim
if [ $? -ne 0 ]; then
        echo "build failed"
        exit 1
fi

./obj_dir/sparcSequencerSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Test failures found" "$logFile"; then
        echo "FAIL"
        exit 1
fi
if [ $simStatus -ne 0 ]; then
        echo "FAIL: simulator exited with status $simStatus"
        exit 1
fi
echo "PASS"
exit 0

// File: sparcSequencer.f
+incdir+common
common/sparcIsaPkg.sv
common/sparcCtrlPkg.sv
control/branchCond.sv
control/windowMgr.sv
control/ctrlFsm.sv
hdl/pcUnit.sv
hdl/trapQueue.sv
hdl/sparcSequencer.sv
dv/sparcSequencer_assertions.sv
dv/sparcSequencerTb.sv
